/* include/lc3_macros.svh */
`ifndef LC3_MACROS_SVH
`define LC3_MACROS_SVH

// Data path and address width
`define LC3_WORD_W 16

// General register file
`define LC3_REG_COUNT 8
`define LC3_REG_IDX_W 3

// First instruction fetch after reset
`define LC3_RESET_PC 16'h3000

// Opcode field of the instruction word
`define LC3_OPCODE_HI 15
`define LC3_OPCODE_LO 12

`endif

/* src/lc3_pkg.sv */
package lc3_pkg;

  // LC-3 opcode encodings, dropped codes included for disassembly
  typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ld   = 4'b0010,
    op_st   = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_res  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
  } opcode_t;

  typedef enum logic [3:0] {
    st_fetch, st_decode, st_execute, st_mem_read, st_mem_write, st_writeback, st_update_pc
  } cycle_state_t;

  typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} alu_op_t;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_addr} wb_sel_t;      // Writeback source
  typedef enum logic {base_next_pc, base_reg} addr_base_t;         // Address adder base
  typedef enum logic [1:0] {off_9, off_6, off_zero} offset_sel_t;

  typedef struct packed {
    logic n;
    logic z;
    logic p;
  } cond_t;

  typedef struct packed {
    alu_op_t     alu_op;
    logic        use_imm;    // imm5 as second ALU operand
    wb_sel_t     wb_sel;
    addr_base_t  addr_base;
    offset_sel_t offset_sel;
    logic        reg_write;  // Register write this cycle
    logic        set_cc;     // Update n/z/p with the write
    logic        branch;     // BR or JMP
  } ctrl_t;

endpackage

/* src/mem_req_if.sv */
`timescale 1ns/100ps
`include "lc3_macros.svh"

// One requester's view of the shared memory port
interface mem_req_if;
  logic                   req;    // Held until done
  logic                   we;     // High for a write
  logic [`LC3_WORD_W-1:0] addr;
  logic [`LC3_WORD_W-1:0] wdata;
  logic [`LC3_WORD_W-1:0] rdata;  // Valid with done
  logic                   done;   // Single cycle completion

  modport requester (
    output req, we, addr, wdata,
    input  rdata, done
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output rdata, done
  );
endinterface

/* src/lc3_fetch.sv */
`timescale 1ns/100ps
`include "lc3_macros.svh"

module lc3_fetch (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   fetch_start,
  input  logic                   pc_load,
  input  logic                   branch_taken,
  input  logic [`LC3_WORD_W-1:0] target,
  output logic [`LC3_WORD_W-1:0] next_pc,
  output logic [`LC3_WORD_W-1:0] instr,
  output logic                   instr_valid,
  mem_req_if.requester           mem
);

  logic [`LC3_WORD_W-1:0] pc;
  logic                   req_q;

  assign next_pc = pc + 1'b1;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      pc    <= `LC3_RESET_PC;
      req_q <= 1'b0;
    end
    else
    begin
      if (pc_load)
        pc <= branch_taken ? target : next_pc;  // Redirect or step
      if (fetch_start)
        req_q <= 1'b1;
      else if (mem.done)
        req_q <= 1'b0;                           // Drop after completion
    end
  end

  assign mem.req   = req_q;
  assign mem.we    = 1'b0;                        // Fetch only reads
  assign mem.addr  = pc;
  assign mem.wdata = '0;

  assign instr_valid = mem.done;
  assign instr       = mem.rdata;  // Word visible in done cycle

endmodule

/* src/lc3_data_access.sv */
`timescale 1ns/100ps
`include "lc3_macros.svh"

module lc3_data_access (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   access_start,
  input  logic                   access_write,
  input  logic [`LC3_WORD_W-1:0] access_addr,
  input  logic [`LC3_WORD_W-1:0] store_data,
  output logic [`LC3_WORD_W-1:0] load_data,
  output logic                   access_done,
  mem_req_if.requester           mem
);

  logic                   req_q;
  logic                   we_q;
  logic [`LC3_WORD_W-1:0] addr_q;   // Address latched at start
  logic [`LC3_WORD_W-1:0] wdata_q;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      req_q <= 1'b0;
      we_q  <= 1'b0;
    end
    else if (access_start)
    begin
      req_q <= 1'b1;
      we_q  <= access_write;
    end
    else if (mem.done)
      req_q <= 1'b0;
  end

  always_ff @(posedge clock)
  begin
    if (access_start)
    begin
      addr_q  <= access_addr;
      wdata_q <= store_data;
    end
    if (mem.done && !we_q)
      load_data <= mem.rdata;  // Held for writeback
  end

  assign mem.req   = req_q;
  assign mem.we    = we_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  assign access_done = mem.done;

endmodule

/* src/lc3_bus_arbiter.sv */
`timescale 1ns/100ps
`include "lc3_macros.svh"

module lc3_bus_arbiter (
  input  logic                   clock,
  input  logic                   reset,
  mem_req_if.arbiter             fetch_port,
  mem_req_if.arbiter             data_port,
  output logic                   mem_req,
  output logic                   mem_we,
  output logic [`LC3_WORD_W-1:0] mem_addr,
  output logic [`LC3_WORD_W-1:0] mem_wdata,
  input  logic [`LC3_WORD_W-1:0] mem_rdata,
  input  logic                   mem_done
);

  logic busy;        // Transaction in flight
  logic grant_data;  // Owner of the in-flight transaction
  logic sel_data;    // Current owner is data access

  // Data access wins a fresh arbitration, grant is kept while busy
  assign sel_data = busy ? grant_data : data_port.req;

  assign mem_req   = sel_data ? data_port.req   : fetch_port.req;
  assign mem_we    = sel_data ? data_port.we    : fetch_port.we;
  assign mem_addr  = sel_data ? data_port.addr  : fetch_port.addr;
  assign mem_wdata = sel_data ? data_port.wdata : fetch_port.wdata;

  // Completion only to the owner
  assign data_port.done   = mem_done && sel_data;
  assign fetch_port.done  = mem_done && !sel_data;
  assign data_port.rdata  = sel_data ? mem_rdata : '0;
  assign fetch_port.rdata = sel_data ? '0 : mem_rdata;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      busy       <= 1'b0;
      grant_data <= 1'b0;
    end
    else
    begin
      busy       <= mem_req && !mem_done;  // Re-arbitrate after done
      grant_data <= sel_data;
    end
  end

endmodule

/* src/lc3_control.sv */
`timescale 1ns/100ps
`include "lc3_macros.svh"

module lc3_control (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`LC3_WORD_W-1:0]   instr,
  input  logic                     instr_valid,
  input  logic                     access_done,
  input  lc3_pkg::cond_t           cond,
  output logic                     fetch_start,
  output logic                     access_start,
  output logic                     access_write,
  output logic                     pc_load,
  output logic                     branch_taken,
  output lc3_pkg::ctrl_t           ctrl,
  output logic [`LC3_REG_IDX_W-1:0] dst_idx,
  output logic [`LC3_REG_IDX_W-1:0] src1_idx,
  output logic [`LC3_REG_IDX_W-1:0] src2_idx,
  output logic [`LC3_WORD_W-1:0]   imm
);

  lc3_pkg::cycle_state_t  state;
  lc3_pkg::opcode_t       opcode;
  lc3_pkg::ctrl_t         dec;       // Decode before state gating
  logic [`LC3_WORD_W-1:0] ir;
  logic                   running;   // Set after the first cycle out of reset
  logic                   is_load;
  logic                   is_store;
  logic                   is_valid;  // Supported opcode

  assign opcode = lc3_pkg::opcode_t'(ir[`LC3_OPCODE_HI:`LC3_OPCODE_LO]);

  always_comb
  begin
    dec.alu_op     = lc3_pkg::alu_pass;
    dec.use_imm    = 1'b0;
    dec.wb_sel     = lc3_pkg::wb_alu;
    dec.addr_base  = lc3_pkg::base_next_pc;
    dec.offset_sel = lc3_pkg::off_zero;
    dec.reg_write  = 1'b0;
    dec.set_cc     = 1'b0;
    dec.branch     = 1'b0;
    is_load        = 1'b0;
    is_store       = 1'b0;
    is_valid       = 1'b1;
    case (opcode)
      lc3_pkg::op_add, lc3_pkg::op_and, lc3_pkg::op_not:
      begin
        dec.alu_op    = (opcode == lc3_pkg::op_add) ? lc3_pkg::alu_add :
                        (opcode == lc3_pkg::op_and) ? lc3_pkg::alu_and : lc3_pkg::alu_not;
        dec.use_imm   = ir[5] && (opcode != lc3_pkg::op_not);  // Immediate form
        dec.reg_write = 1'b1;
        dec.set_cc    = 1'b1;
      end
      lc3_pkg::op_br:
      begin
        dec.offset_sel = lc3_pkg::off_9;  // PC relative target
        dec.branch     = 1'b1;
      end
      lc3_pkg::op_jmp:
      begin
        dec.addr_base = lc3_pkg::base_reg;  // BaseR plus zero, RET too
        dec.branch    = 1'b1;
      end
      lc3_pkg::op_ld, lc3_pkg::op_ldr, lc3_pkg::op_lea:
      begin
        dec.addr_base  = (opcode == lc3_pkg::op_ldr) ? lc3_pkg::base_reg : lc3_pkg::base_next_pc;
        dec.offset_sel = (opcode == lc3_pkg::op_ldr) ? lc3_pkg::off_6 : lc3_pkg::off_9;
        dec.wb_sel     = (opcode == lc3_pkg::op_lea) ? lc3_pkg::wb_addr : lc3_pkg::wb_mem;
        dec.reg_write  = 1'b1;
        dec.set_cc     = 1'b1;
        is_load        = (opcode != lc3_pkg::op_lea);
      end
      lc3_pkg::op_st, lc3_pkg::op_str:
      begin
        dec.addr_base  = (opcode == lc3_pkg::op_str) ? lc3_pkg::base_reg : lc3_pkg::base_next_pc;
        dec.offset_sel = (opcode == lc3_pkg::op_str) ? lc3_pkg::off_6 : lc3_pkg::off_9;
        is_store       = 1'b1;
      end
      default:
        is_valid = 1'b0;  // JSR, LDI, STI, RTI, TRAP, reserved
    endcase
  end

  // Sign extended operand chosen by the decoded offset
  always_comb
  begin
    case (dec.offset_sel)
      lc3_pkg::off_9: imm = {{(`LC3_WORD_W-9){ir[8]}}, ir[8:0]};
      lc3_pkg::off_6: imm = {{(`LC3_WORD_W-6){ir[5]}}, ir[5:0]};
      default:        imm = dec.use_imm ? {{(`LC3_WORD_W-5){ir[4]}}, ir[4:0]} : '0;
    endcase
  end

  assign dst_idx  = ir[11:9];
  assign src1_idx = ir[8:6];                      // SR1 or BaseR
  assign src2_idx = is_store ? ir[11:9] : ir[2:0];  // SR for stores

  // Register write only in the writeback cycle
  always_comb
  begin
    ctrl           = dec;
    ctrl.reg_write = dec.reg_write && (state == lc3_pkg::st_writeback);
  end

  assign access_write = is_store;
  assign pc_load      = (state == lc3_pkg::st_update_pc);
  assign branch_taken = dec.branch && ((opcode == lc3_pkg::op_jmp) || |(ir[11:9] & cond));

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state        <= lc3_pkg::st_fetch;
      running      <= 1'b0;
      fetch_start  <= 1'b0;
      access_start <= 1'b0;
    end
    else
    begin
      running      <= 1'b1;
      fetch_start  <= !running || (state == lc3_pkg::st_update_pc);  // First fetch and each next
      access_start <= (state == lc3_pkg::st_execute) && (is_load || is_store);
      case (state)
        lc3_pkg::st_fetch:
          if (instr_valid)
            state <= lc3_pkg::st_decode;
        lc3_pkg::st_decode:
          state <= is_valid ? lc3_pkg::st_execute : lc3_pkg::st_update_pc;  // No-op skip
        lc3_pkg::st_execute:
          if (dec.branch)
            state <= lc3_pkg::st_update_pc;
          else if (is_load)
            state <= lc3_pkg::st_mem_read;
          else if (is_store)
            state <= lc3_pkg::st_mem_write;
          else
            state <= lc3_pkg::st_writeback;
        lc3_pkg::st_mem_read:
          if (access_done)
            state <= lc3_pkg::st_writeback;
        lc3_pkg::st_mem_write:
          if (access_done)
            state <= lc3_pkg::st_update_pc;
        lc3_pkg::st_writeback:
          state <= lc3_pkg::st_update_pc;
        default:
          state <= lc3_pkg::st_fetch;
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (state == lc3_pkg::st_fetch && instr_valid)
      ir <= instr;  // Instruction register
  end

endmodule

/* src/lc3_datapath.sv */
`timescale 1ns/100ps
`include "lc3_macros.svh"

module lc3_datapath (
  input  logic                      clock,
  input  logic                      reset,
  input  lc3_pkg::ctrl_t            ctrl,
  input  logic [`LC3_REG_IDX_W-1:0] dst_idx,
  input  logic [`LC3_REG_IDX_W-1:0] src1_idx,
  input  logic [`LC3_REG_IDX_W-1:0] src2_idx,
  input  logic [`LC3_WORD_W-1:0]    imm,
  input  logic [`LC3_WORD_W-1:0]    next_pc,
  input  logic [`LC3_WORD_W-1:0]    load_data,
  output logic [`LC3_WORD_W-1:0]    addr_out,
  output logic [`LC3_WORD_W-1:0]    store_data,
  output lc3_pkg::cond_t            cond
);

  logic [`LC3_WORD_W-1:0] regs [`LC3_REG_COUNT];
  logic [`LC3_WORD_W-1:0] src1_val;
  logic [`LC3_WORD_W-1:0] src2_val;
  logic [`LC3_WORD_W-1:0] alu_b;      // Second ALU operand
  logic [`LC3_WORD_W-1:0] alu_out;
  logic [`LC3_WORD_W-1:0] offset;
  logic [`LC3_WORD_W-1:0] base;
  logic [`LC3_WORD_W-1:0] wb_data;

  assign src1_val   = regs[src1_idx];
  assign src2_val   = regs[src2_idx];
  assign store_data = src2_val;  // ST and STR source

  assign alu_b = ctrl.use_imm ? imm : src2_val;

  always_comb
  begin
    case (ctrl.alu_op)
      lc3_pkg::alu_add: alu_out = src1_val + alu_b;
      lc3_pkg::alu_and: alu_out = src1_val & alu_b;
      lc3_pkg::alu_not: alu_out = ~src1_val;
      default:          alu_out = src1_val;  // Pass through
    endcase
  end

  // Address adder for loads, stores, LEA and jump targets
  always_comb
  begin
    case (ctrl.offset_sel)
      lc3_pkg::off_9, lc3_pkg::off_6: offset = imm;
      default:                        offset = '0;
    endcase
  end

  assign base     = (ctrl.addr_base == lc3_pkg::base_reg) ? src1_val : next_pc;
  assign addr_out = base + offset;

  always_comb
  begin
    case (ctrl.wb_sel)
      lc3_pkg::wb_mem:  wb_data = load_data;
      lc3_pkg::wb_addr: wb_data = addr_out;   // LEA
      default:          wb_data = alu_out;
    endcase
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `LC3_REG_COUNT; i++)
        regs[i] <= '0;
      cond <= '{n: 1'b0, z: 1'b1, p: 1'b0};  // Zero after reset
    end
    else if (ctrl.reg_write)
    begin
      regs[dst_idx] <= wb_data;
      if (ctrl.set_cc)
      begin
        cond.n <= wb_data[`LC3_WORD_W-1];
        cond.z <= (wb_data == '0);
        cond.p <= !wb_data[`LC3_WORD_W-1] && (wb_data != '0);
      end
    end
  end

endmodule

/* src/simple_lc3.sv */
`timescale 1ns/100ps
`include "lc3_macros.svh"

module simple_lc3 (
  input  logic                   clock,
  input  logic                   reset,
  output logic                   mem_req,
  output logic                   mem_we,
  output logic [`LC3_WORD_W-1:0] mem_addr,
  output logic [`LC3_WORD_W-1:0] mem_wdata,
  input  logic [`LC3_WORD_W-1:0] mem_rdata,
  input  logic                   mem_done
);

  logic                      fetch_start;
  logic                      pc_load;
  logic                      branch_taken;
  logic [`LC3_WORD_W-1:0]    next_pc;
  logic [`LC3_WORD_W-1:0]    instr;
  logic                      instr_valid;
  logic                      access_start;
  logic                      access_write;
  logic                      access_done;
  logic [`LC3_WORD_W-1:0]    load_data;
  logic [`LC3_WORD_W-1:0]    store_data;
  logic [`LC3_WORD_W-1:0]    addr_out;  // Data address, LEA value, jump target
  logic [`LC3_WORD_W-1:0]    imm;
  logic [`LC3_REG_IDX_W-1:0] dst_idx;
  logic [`LC3_REG_IDX_W-1:0] src1_idx;
  logic [`LC3_REG_IDX_W-1:0] src2_idx;
  lc3_pkg::ctrl_t            ctrl;
  lc3_pkg::cond_t            cond;

  mem_req_if fetch_bus ();
  mem_req_if data_bus ();

  lc3_fetch u_fetch (
    .clock, .reset, .fetch_start, .pc_load, .branch_taken,
    .target (addr_out), .next_pc, .instr, .instr_valid, .mem (fetch_bus.requester)
  );

  lc3_data_access u_data_access (
    .clock, .reset, .access_start, .access_write, .access_addr (addr_out),
    .store_data, .load_data, .access_done, .mem (data_bus.requester)
  );

  lc3_bus_arbiter u_arbiter (
    .clock, .reset, .fetch_port (fetch_bus.arbiter), .data_port (data_bus.arbiter),
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_done
  );

  lc3_control u_control (
    .clock, .reset, .instr, .instr_valid, .access_done, .cond,
    .fetch_start, .access_start, .access_write, .pc_load, .branch_taken,
    .ctrl, .dst_idx, .src1_idx, .src2_idx, .imm
  );

  lc3_datapath u_datapath (
    .clock, .reset, .ctrl, .dst_idx, .src1_idx, .src2_idx, .imm,
    .next_pc, .load_data, .addr_out, .store_data, .cond
  );

endmodule

/* test/lc3_assertions.sv */
`timescale 1ns/100ps

// Handshake rules of the shared memory port
module lc3_assertions (
  input logic        clock,
  input logic        reset,
  input logic        mem_req,
  input logic        mem_we,
  input logic [15:0] mem_addr,
  input logic [15:0] mem_wdata,
  input logic        mem_done
);

  // Request fields frozen until completion
  a_req_hold: assert property (@(posedge clock) disable iff (reset)
    mem_req && !mem_done |=> mem_req && $stable(mem_addr) && $stable(mem_we)
                             && $stable(mem_wdata))
    else $error("memory request changed before done");

  a_no_req_in_reset: assert property (@(posedge clock) reset |-> !mem_req)
    else $error("memory request raised during reset");

endmodule

bind simple_lc3 lc3_assertions u_assertions (.*);

/* test/lc3_checker.sv */
`timescale 1ns/100ps
`include "lc3_macros.svh"

module lc3_checker (
  input  logic        clock,
  input  logic        reset,
  input  logic        mem_req,
  input  logic        mem_we,
  input  logic [15:0] mem_addr,
  input  logic [15:0] mem_wdata,
  input  logic        mem_done,
  input  logic [15:0] exp_addr [64],  // Expected stores in order
  input  logic [15:0] exp_data [64],
  input  int          exp_count,
  input  logic        test_end,       // Pulse after the halt fetch
  input  int          test_id,
  input  logic        report,
  output int          error_count
);

  int   idx = 0;
  int   test_errors = 0;
  int   tests_run = 0;
  logic first_seen = 1'b0;  // First request after reset checked

  initial error_count = 0;

  always @(posedge clock)
  begin
    if (reset)
      first_seen = 1'b0;
    else
    begin
      if (mem_req && !first_seen)
      begin
        first_seen = 1'b1;
        if (mem_addr !== `LC3_RESET_PC)
        begin
          $display("CHECK FAILED mem_addr first request: expected %h got %h",
                   `LC3_RESET_PC, mem_addr);
          test_errors++;
        end
        if (mem_we !== 1'b0)
        begin
          $display("CHECK FAILED mem_we first request: expected 0 got %h", mem_we);
          test_errors++;
        end
      end
      if (mem_req && mem_we && mem_done)
      begin
        if (idx >= exp_count)
        begin
          $display("test %0d: unexpected store of %h to address %h", test_id, mem_wdata,
                   mem_addr);
          test_errors++;
        end
        else
        begin
          if (mem_addr !== exp_addr[idx])
          begin
            $display("CHECK FAILED mem_addr store %0d: expected %h got %h", idx,
                     exp_addr[idx], mem_addr);
            test_errors++;
          end
          if (mem_wdata !== exp_data[idx])
          begin
            $display("CHECK FAILED mem_wdata store %0d: expected %h got %h", idx,
                     exp_data[idx], mem_wdata);
            test_errors++;
          end
        end
        idx++;
      end
    end
    if (test_end)
    begin
      if (idx < exp_count)
      begin
        $display("test %0d: %0d expected stores never happened", test_id, exp_count - idx);
        test_errors++;
      end
      $display("test %0d finished: %0d stores seen, %0d expected, %0d errors", test_id, idx,
               exp_count, test_errors);
      error_count += test_errors;
      tests_run++;
      idx         = 0;
      test_errors = 0;
    end
    if (report)
      $display("%0d tests run, %0d errors", tests_run, error_count);
  end

endmodule

/* test/tb_simple_lc3.sv */
`timescale 1ns/100ps
`include "lc3_macros.svh"

module tb_simple_lc3;

  localparam int NUM_TESTS = 6;
  localparam int MAX_INSTR = 100;         // Model step limit per program
  localparam int CYCLES_PER_INSTR = 20;   // Two accesses at 5 waits plus FSM states
  localparam int WATCH_NS = NUM_TESTS * (MAX_INSTR * CYCLES_PER_INSTR + 20) * 4;
  localparam logic [15:0] HALT = 16'h0FFF;  // BRnzp to itself

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic        mem_req;
  logic        mem_we;
  logic [15:0] mem_addr;
  logic [15:0] mem_wdata;
  logic [15:0] mem_rdata = '0;
  logic        mem_done = 1'b0;

  logic [15:0] mem [0:65535];
  logic [15:0] ref_mem [0:65535];  // Image seen by the ISA model
  logic [15:0] exp_addr [64];
  logic [15:0] exp_data [64];
  int          exp_count = 0;
  logic        test_end = 1'b0;
  logic        report = 1'b0;
  int          test_id = 0;
  int          error_count;
  int          lat_max = 0;        // Memory wait cycles upper bound
  int          wait_left = 0;
  logic        waiting = 1'b0;
  logic [15:0] wp;                 // Program write pointer
  logic [15:0] halt_addr;

  always #2 clock = ~clock;

  simple_lc3 dut0 (.*);

  lc3_checker checker0 (
    .clock, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_done,
    .exp_addr, .exp_data, .exp_count, .test_end, .test_id, .report, .error_count
  );

  // Memory model, answers on the falling edge after a random wait
  always @(negedge clock)
  begin
    if (mem_done)
      mem_done <= 1'b0;
    else if (mem_req)
    begin
      if (!waiting)
      begin
        wait_left = (lat_max > 0) ? int'($urandom % (lat_max + 1)) : 0;
        waiting   = 1'b1;
      end
      if (wait_left == 0)
      begin
        mem_rdata <= mem[mem_addr];
        if (mem_we)
          mem[mem_addr] = mem_wdata;
        mem_done <= 1'b1;
        waiting   = 1'b0;
      end
      else
        wait_left--;
    end
  end

  function automatic logic [15:0] sext(logic [15:0] x, int bits);
    return 16'($signed(x << (16 - bits)) >>> (16 - bits));
  endfunction

  function automatic logic [15:0] enc_rrr(logic [3:0] op, int dr, int sr1, int sr2);
    return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
  endfunction

  function automatic logic [15:0] enc_ri(logic [3:0] op, int dr, int sr1, int imm5);
    return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm5)};
  endfunction

  function automatic logic [15:0] enc_off9(logic [3:0] op, int dr, int off9);
    return {op, 3'(dr), 9'(off9)};
  endfunction

  function automatic logic [15:0] enc_off6(logic [3:0] op, int dr, int base, int off6);
    return {op, 3'(dr), 3'(base), 6'(off6)};
  endfunction

  // ISA reference, steps ref_mem and lists the stores it makes
  function automatic void run_model();
    logic [15:0] r [8];
    logic [15:0] pc;
    logic [15:0] ir;
    logic [15:0] v;
    logic [15:0] ea;
    logic        n;
    logic        z;
    logic        p;
    logic        wr;
    for (int i = 0; i < 8; i++)
      r[i] = '0;
    {n, z, p} = 3'b010;
    pc        = `LC3_RESET_PC;
    exp_count = 0;
    for (int steps = 0; steps < MAX_INSTR; steps++)
    begin
      ir = ref_mem[pc];
      if (ir == HALT)
        break;
      pc = pc + 1;
      wr = 1'b0;
      v  = '0;
      case (lc3_pkg::opcode_t'(ir[15:12]))
        lc3_pkg::op_add:
        begin
          v  = r[ir[8:6]] + (ir[5] ? sext(ir, 5) : r[ir[2:0]]);
          wr = 1'b1;
        end
        lc3_pkg::op_and:
        begin
          v  = r[ir[8:6]] & (ir[5] ? sext(ir, 5) : r[ir[2:0]]);
          wr = 1'b1;
        end
        lc3_pkg::op_not:
        begin
          v  = ~r[ir[8:6]];
          wr = 1'b1;
        end
        lc3_pkg::op_br:
          if (|(ir[11:9] & {n, z, p}))
            pc = pc + sext(ir, 9);
        lc3_pkg::op_jmp: pc = r[ir[8:6]];
        lc3_pkg::op_ld:
        begin
          v  = ref_mem[pc + sext(ir, 9)];
          wr = 1'b1;
        end
        lc3_pkg::op_ldr:
        begin
          v  = ref_mem[r[ir[8:6]] + sext(ir, 6)];
          wr = 1'b1;
        end
        lc3_pkg::op_lea:
        begin
          v  = pc + sext(ir, 9);
          wr = 1'b1;
        end
        lc3_pkg::op_st, lc3_pkg::op_str:
        begin
          ea = (ir[15:12] == 4'h3) ? pc + sext(ir, 9) : r[ir[8:6]] + sext(ir, 6);
          ref_mem[ea] = r[ir[11:9]];
          if (exp_count < 64)
          begin
            exp_addr[exp_count] = ea;
            exp_data[exp_count] = r[ir[11:9]];
            exp_count++;
          end
        end
        default: ;  // JSR, LDI, STI, RTI, TRAP, reserved do nothing
      endcase
      if (wr)
      begin
        r[ir[11:9]] = v;
        n = v[15];
        z = (v == 16'h0000);
        p = !v[15] && (v != 16'h0000);
      end
    end
  endfunction

  task automatic emit(input logic [15:0] w);
    mem[wp] = w;
    wp      = wp + 1;
  endtask

  task automatic begin_image();
    for (int a = 0; a < 65536; a++)
      mem[a] = {8'(a), 8'(a >> 8)} ^ 16'h5A3C;  // Whole address pattern
    wp = `LC3_RESET_PC;
  endtask

  task automatic build_alu();
    mem[16'h3100] = 16'($urandom);
    mem[16'h3101] = 16'($urandom);
    emit(enc_off9(4'hE, 6, 255));     // LEA R6 to 0x3100
    emit(enc_ri(4'h1, 7, 6, 15));     // R7 store base
    emit(enc_off6(4'h6, 1, 6, 0));
    emit(enc_off6(4'h6, 2, 6, 1));
    emit(enc_rrr(4'h1, 3, 1, 2));
    emit(enc_off6(4'h7, 3, 7, 0));
    emit(enc_ri(4'h1, 3, 1, int'($urandom % 32)));
    emit(enc_off6(4'h7, 3, 7, 1));
    emit(enc_rrr(4'h5, 3, 1, 2));
    emit(enc_off6(4'h7, 3, 7, 2));
    emit(enc_ri(4'h5, 3, 2, int'($urandom % 32)));
    emit(enc_off9(4'h3, 3, 100));
    emit({4'h9, 3'd3, 3'd1, 6'h3F});  // NOT R3, R1
    emit(enc_off6(4'h7, 3, 7, 3));
  endtask

  // Reset the DUT, run the image to the halt loop, then close the test
  task automatic run_test(input int id, input int lat);
    halt_addr = wp;
    emit(HALT);
    for (int a = 0; a < 65536; a++)
      ref_mem[a] = mem[a];
    run_model();
    test_id = id;
    lat_max = lat;
    reset   = 1'b1;
    repeat (5) @(negedge clock);
    reset = 1'b0;
    do
      @(posedge clock);
    while (!(mem_req && mem_done && !mem_we && mem_addr == halt_addr));
    @(negedge clock);
    test_end = 1'b1;
    @(negedge clock);
    test_end = 1'b0;
  endtask

  initial
  begin
    void'($urandom(83686));
    @(negedge clock);
    // Reset and first fetch
    begin_image();
    emit(enc_ri(4'h1, 1, 0, 7));
    emit(enc_off9(4'h3, 1, 4));
    run_test(1, 0);
    // ALU operations with random operands
    begin_image();
    build_alu();
    run_test(2, 0);
    // Loads and LEA
    begin_image();
    emit(enc_off9(4'hE, 6, 255));
    mem[wp + 201] = 16'($urandom);
    emit(enc_off9(4'h2, 1, 200));
    emit(enc_off9(4'h3, 1, 150));
    mem[16'h3105] = 16'($urandom);
    emit(enc_off6(4'h6, 2, 6, 5));
    emit(enc_off6(4'h7, 2, 6, 20));
    emit(enc_off9(4'hE, 3, -3));
    emit(enc_off9(4'h3, 3, 150));
    mem[16'h30FE] = 16'($urandom);
    emit(enc_off6(4'h6, 4, 6, -2));
    emit(enc_off9(4'h3, 4, 150));
    run_test(3, 0);
    // Branches over every n/z/p case, then JMP
    begin_image();
    emit(enc_ri(4'h1, 2, 0, 9));
    for (int c = 0; c < 3; c++)
      for (int m = 0; m < 8; m++)
      begin
        emit(enc_ri(4'h1, 1, 0, (c == 0) ? -3 : (c == 1) ? 0 : 5));
        emit(enc_off9(4'h0, m, 1));
        emit(enc_off9(4'h3, 2, 120));
      end
    emit(enc_off9(4'hE, 5, 2));
    emit({4'hC, 3'd0, 3'd5, 6'd0});   // JMP R5
    emit(enc_off9(4'h3, 2, 120));
    emit(enc_off9(4'h3, 2, 120));
    run_test(4, 0);
    // Dropped opcodes behave as no-ops
    begin_image();
    emit(enc_ri(4'h1, 2, 0, 11));
    emit(enc_ri(4'h1, 1, 0, 4));
    emit(16'h4805);                   // JSR
    emit(enc_off9(4'h3, 2, 60));
    emit(enc_off9(4'hA, 1, 3));       // LDI
    emit(enc_off9(4'h3, 1, 60));
    emit(enc_off9(4'hB, 2, 40));      // STI
    emit(16'hF025);                   // TRAP
    emit(16'h8000);                   // RTI
    emit(16'hD123);                   // Reserved
    emit(enc_off9(4'h3, 1, 60));
    run_test(5, 0);
    // ALU program again under memory back-pressure
    begin_image();
    build_alu();
    run_test(6, 5);
    @(negedge clock);
    report = 1'b1;
    @(negedge clock);
    report = 1'b0;
    if (error_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    #(WATCH_NS);
    $display("timeout: the program did not reach its halt loop in time");
    $display("Regression failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
src/lc3_pkg.sv
src/mem_req_if.sv
src/lc3_fetch.sv
src/lc3_data_access.sv
src/lc3_bus_arbiter.sv
src/lc3_control.sv
src/lc3_datapath.sv
src/simple_lc3.sv
test/lc3_assertions.sv
test/lc3_checker.sv
test/tb_simple_lc3.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_simple_lc3
FILELIST ?= vlog.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the regression with $(TOOL)"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o sim
	./$(BUILD)/sim 2>&1 | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
